//--- common/mem_bus_pkg.sv
`default_nettype none

package mem_bus_pkg;

    // ------------------------------------------------------------------
    // Bus widths
    // ------------------------------------------------------------------
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = 4;

    // Top address byte selects the region
    localparam int REGION_W = 8;

    // ------------------------------------------------------------------
    // Opcodes and sequencer states
    // ------------------------------------------------------------------
    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_e;

    typedef enum logic [1:0] {
        SEQ_IDLE  = 2'd0,
        SEQ_ISSUE = 2'd1,
        SEQ_WAIT  = 2'd2
    } seq_state_e;

    // Stored request is {op, addr, wdata, wstrb}
    localparam int REQ_W = 1 + ADDR_W + DATA_W + STRB_W;

endpackage

`default_nettype wire

//--- common/mem_map_pkg.sv
`default_nettype none

package mem_map_pkg;

    // ------------------------------------------------------------------
    // Region bases, compared with the top address byte
    // ------------------------------------------------------------------
    localparam logic [7:0] BASE_BRAM = 8'h00;
    localparam logic [7:0] BASE_GPIO = 8'h01;

    // ------------------------------------------------------------------
    // GPIO register map, word offsets inside the region
    // ------------------------------------------------------------------
    // Output register, read/write
    localparam int unsigned GPIO_OUT_OFS = 0;
    // Sampled input, read only
    localparam int unsigned GPIO_IN_OFS = 1;

endpackage

`default_nettype wire

//--- hw/req_fifo.sv
`default_nettype none
`timescale 1ns/100ps

module req_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  wire logic                                clk,
    input  wire logic                                rst_n,
    input  wire logic                                cmd_valid,
    input  mem_bus_pkg::mem_op_e                     cmd_op,
    input  wire logic [mem_bus_pkg::ADDR_W-1:0]      cmd_addr,
    input  wire logic [mem_bus_pkg::DATA_W-1:0]      cmd_wdata,
    input  wire logic [mem_bus_pkg::STRB_W-1:0]      cmd_wstrb,
    input  wire logic                                fifo_pop,
    output logic                                     fifo_empty,
    output mem_bus_pkg::mem_op_e                     head_op,
    output logic [mem_bus_pkg::ADDR_W-1:0]           head_addr,
    output logic [mem_bus_pkg::DATA_W-1:0]           head_wdata,
    output logic [mem_bus_pkg::STRB_W-1:0]           head_wstrb,
    output logic                                     credit_return
);
    import mem_bus_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [REQ_W-1:0] store [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             fifo_full;
    logic             push;
    logic             pop;
    logic [REQ_W-1:0] head_entry;

    assign fifo_empty = (count == '0);
    assign fifo_full  = (count == CNT_W'(FIFO_DEPTH));

    // No ready: the host's credits keep writes within the free slots
    assign push = cmd_valid;
    assign pop  = fifo_pop && !fifo_empty;

    // Head entry unpacked for the sequencer
    assign head_entry = store[rd_ptr];
    assign head_op    = mem_op_e'(head_entry[REQ_W-1]);
    assign head_addr  = head_entry[STRB_W+DATA_W +: ADDR_W];
    assign head_wdata = head_entry[STRB_W +: DATA_W];
    assign head_wstrb = head_entry[0 +: STRB_W];

    always_ff @(posedge clk) begin
        if (push) begin
            store[wr_ptr] <= {cmd_op, cmd_addr, cmd_wdata, cmd_wstrb};
        end
    end

    // ------------------------------------------------------------------
    // Pointers, count and credit pulse
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // One credit per freed slot, a cycle after the pop
            credit_return <= pop;
        end
    end

    // Host spent more credits than it owns
    assert property (@(posedge clk) disable iff (!rst_n) cmd_valid |-> !fifo_full);

    assert property (@(posedge clk) disable iff (!rst_n) fifo_pop |-> !fifo_empty);

endmodule

`default_nettype wire

//--- hw/bus_sequencer.sv
`default_nettype none
`timescale 1ns/100ps

module bus_sequencer #(
    parameter int TIMEOUT_CYCLES = 8
) (
    input  wire logic                                clk,
    input  wire logic                                rst_n,
    input  wire logic                                fifo_empty,
    input  mem_bus_pkg::mem_op_e                     head_op,
    input  wire logic [mem_bus_pkg::ADDR_W-1:0]      head_addr,
    input  wire logic [mem_bus_pkg::DATA_W-1:0]      head_wdata,
    input  wire logic [mem_bus_pkg::STRB_W-1:0]      head_wstrb,
    input  wire logic                                ret_ready,
    input  wire logic [mem_bus_pkg::DATA_W-1:0]      ret_rdata,
    output logic                                     fifo_pop,
    output logic                                     bus_valid,
    output logic                                     bus_write,
    output logic [mem_bus_pkg::ADDR_W-1:0]           bus_addr,
    output logic [mem_bus_pkg::DATA_W-1:0]           bus_wdata,
    output logic [mem_bus_pkg::STRB_W-1:0]           bus_wstrb,
    output logic                                     rsp_valid,
    output logic [mem_bus_pkg::DATA_W-1:0]           rsp_rdata,
    output logic                                     rsp_err
);
    import mem_bus_pkg::*;

    localparam int WAIT_W = $clog2(TIMEOUT_CYCLES + 1);

    seq_state_e        state;
    logic [WAIT_W-1:0] wait_cnt;
    mem_op_e           req_op;
    logic [ADDR_W-1:0] req_addr;
    logic [DATA_W-1:0] req_wdata;
    logic [STRB_W-1:0] req_wstrb;

    assign fifo_pop = (state == SEQ_IDLE) && !fifo_empty;

    // Forward bus straight from the held request
    assign bus_valid = (state == SEQ_ISSUE) || (state == SEQ_WAIT);
    assign bus_write = (req_op == MEM_WRITE);
    assign bus_addr  = req_addr;
    assign bus_wdata = req_wdata;
    assign bus_wstrb = req_wstrb;

    always_ff @(posedge clk) begin
        if (fifo_pop) begin
            req_op    <= head_op;
            req_addr  <= head_addr;
            req_wdata <= head_wdata;
            req_wstrb <= head_wstrb;
        end
        // Writes and timeouts return zero data
        if (state == SEQ_WAIT) begin
            rsp_rdata <= (ret_ready && !bus_write) ? ret_rdata : '0;
        end
    end

    // ------------------------------------------------------------------
    // Request FSM
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= SEQ_IDLE;
            wait_cnt  <= '0;
            rsp_valid <= 1'b0;
            rsp_err   <= 1'b0;
        end else begin
            rsp_valid <= 1'b0;
            rsp_err   <= 1'b0;
            case (state)
                SEQ_IDLE: begin
                    if (!fifo_empty) begin
                        state <= SEQ_ISSUE;
                    end
                end
                SEQ_ISSUE: begin
                    state    <= SEQ_WAIT;
                    wait_cnt <= '0;
                end
                SEQ_WAIT: begin
                    if (ret_ready) begin
                        state     <= SEQ_IDLE;
                        rsp_valid <= 1'b1;
                    end else if (wait_cnt == WAIT_W'(TIMEOUT_CYCLES - 1)) begin
                        // Nobody decoded this address
                        state     <= SEQ_IDLE;
                        rsp_valid <= 1'b1;
                        rsp_err   <= 1'b1;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    // Slaves answer only to a request held on the bus
    assert property (@(posedge clk) disable iff (!rst_n)
        ret_ready |-> (bus_valid && state == SEQ_WAIT));

endmodule

`default_nettype wire

//--- hw/bram_pack.sv
`default_nettype none
`timescale 1ns/100ps

module bram_pack #(
    parameter int                                BRAM_WORDS = 256,
    parameter logic [mem_bus_pkg::REGION_W-1:0]  BASE_ADDR  = mem_map_pkg::BASE_BRAM
) (
    input  wire logic                                clk,
    input  wire logic                                rst_n,
    input  wire logic                                bus_valid,
    input  wire logic                                bus_write,
    input  wire logic [mem_bus_pkg::ADDR_W-1:0]      bus_addr,
    input  wire logic [mem_bus_pkg::DATA_W-1:0]      bus_wdata,
    input  wire logic [mem_bus_pkg::STRB_W-1:0]      bus_wstrb,
    output logic                                     ready,
    output logic [mem_bus_pkg::DATA_W-1:0]           rdata
);
    import mem_bus_pkg::*;

    localparam int IDX_W = (BRAM_WORDS > 1) ? $clog2(BRAM_WORDS) : 1;

    logic [DATA_W-1:0] ram [BRAM_WORDS];
    logic              sel;
    logic              accept;
    logic [ADDR_W-1:0] word_addr;
    logic [IDX_W-1:0]  idx;
    logic              ready_q;
    logic [DATA_W-1:0] rdata_q;

    assign sel    = bus_valid && (bus_addr[ADDR_W-1 -: REGION_W] == BASE_ADDR);
    // First selected cycle only, the sequencer drops bus_valid after ready
    assign accept = sel && !ready_q;

    // Word index wraps inside the array
    assign word_addr = bus_addr >> 2;
    assign idx       = IDX_W'(word_addr % BRAM_WORDS);

    always_ff @(posedge clk) begin
        if (accept) begin
            rdata_q <= ram[idx];
            if (bus_write) begin
                for (int b = 0; b < STRB_W; b++) begin
                    if (bus_wstrb[b]) begin
                        ram[idx][8*b +: 8] <= bus_wdata[8*b +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= accept;
        end
    end

    // Return bundle is zero unless answering
    assign ready = ready_q;
    assign rdata = ready_q ? rdata_q : '0;

    // Bus released after the ready pulse, else a second access would start
    assert property (@(posedge clk) disable iff (!rst_n) ready |=> !bus_valid);

endmodule

`default_nettype wire

//--- hw/gpio_pack.sv
`default_nettype none
`timescale 1ns/100ps

module gpio_pack #(
    parameter logic [mem_bus_pkg::REGION_W-1:0] BASE_ADDR = mem_map_pkg::BASE_GPIO
) (
    input  wire logic                                clk,
    input  wire logic                                rst_n,
    input  wire logic                                bus_valid,
    input  wire logic                                bus_write,
    input  wire logic [mem_bus_pkg::ADDR_W-1:0]      bus_addr,
    input  wire logic [mem_bus_pkg::DATA_W-1:0]      bus_wdata,
    input  wire logic [mem_bus_pkg::STRB_W-1:0]      bus_wstrb,
    input  wire logic [mem_bus_pkg::DATA_W-1:0]      gpio_in,
    output logic                                     ready,
    output logic [mem_bus_pkg::DATA_W-1:0]           rdata,
    output logic [mem_bus_pkg::DATA_W-1:0]           gpio_out
);
    import mem_bus_pkg::*;
    import mem_map_pkg::*;

    // Word offset bits between the byte lane and the region byte
    localparam int OFS_W = ADDR_W - REGION_W - 2;

    logic              sel;
    logic              accept;
    logic [OFS_W-1:0]  word_ofs;
    logic              ready_q;
    logic [DATA_W-1:0] rdata_q;
    logic [DATA_W-1:0] gpio_in_q;

    assign sel      = bus_valid && (bus_addr[ADDR_W-1 -: REGION_W] == BASE_ADDR);
    assign accept   = sel && !ready_q;
    assign word_ofs = bus_addr[ADDR_W-REGION_W-1:2];

    // Input sampled every cycle
    always_ff @(posedge clk) begin
        gpio_in_q <= gpio_in;
        if (accept) begin
            if (word_ofs == OFS_W'(GPIO_OUT_OFS)) begin
                rdata_q <= gpio_out;
            end else if (word_ofs == OFS_W'(GPIO_IN_OFS)) begin
                rdata_q <= gpio_in_q;
            end else begin
                rdata_q <= '0;
            end
        end
    end

    // Output register takes strobed bytes, other offsets ignore writes
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ready_q  <= 1'b0;
            gpio_out <= '0;
        end else begin
            ready_q <= accept;
            if (accept && bus_write && word_ofs == OFS_W'(GPIO_OUT_OFS)) begin
                for (int b = 0; b < STRB_W; b++) begin
                    if (bus_wstrb[b]) begin
                        gpio_out[8*b +: 8] <= bus_wdata[8*b +: 8];
                    end
                end
            end
        end
    end

    assign ready = ready_q;
    assign rdata = ready_q ? rdata_q : '0;

endmodule

`default_nettype wire

//--- hw/mem_system.sv
`default_nettype none
`timescale 1ns/100ps

module mem_system #(
    parameter int FIFO_DEPTH     = 4,
    parameter int TIMEOUT_CYCLES = 8,
    parameter int BRAM_WORDS     = 256
) (
    input  wire logic                                clk,
    input  wire logic                                rst_n,
    input  wire logic                                cmd_valid,
    input  mem_bus_pkg::mem_op_e                     cmd_op,
    input  wire logic [mem_bus_pkg::ADDR_W-1:0]      cmd_addr,
    input  wire logic [mem_bus_pkg::DATA_W-1:0]      cmd_wdata,
    input  wire logic [mem_bus_pkg::STRB_W-1:0]      cmd_wstrb,
    input  wire logic [mem_bus_pkg::DATA_W-1:0]      gpio_in,
    output logic                                     credit_return,
    output logic                                     rsp_valid,
    output logic [mem_bus_pkg::DATA_W-1:0]           rsp_rdata,
    output logic                                     rsp_err,
    output logic [mem_bus_pkg::DATA_W-1:0]           gpio_out
);
    import mem_bus_pkg::*;
    import mem_map_pkg::*;

    logic              fifo_empty;
    logic              fifo_pop;
    mem_op_e           head_op;
    logic [ADDR_W-1:0] head_addr;
    logic [DATA_W-1:0] head_wdata;
    logic [STRB_W-1:0] head_wstrb;

    // Packed forward bus
    logic              bus_valid;
    logic              bus_write;
    logic [ADDR_W-1:0] bus_addr;
    logic [DATA_W-1:0] bus_wdata;
    logic [STRB_W-1:0] bus_wstrb;

    // Return bundles
    logic              bram_ready;
    logic [DATA_W-1:0] bram_rdata;
    logic              gpio_ready;
    logic [DATA_W-1:0] gpio_rdata;
    logic              ret_ready;
    logic [DATA_W-1:0] ret_rdata;

    // Unselected slaves drive zero, so OR is enough
    assign ret_ready = bram_ready | gpio_ready;
    assign ret_rdata = bram_rdata | gpio_rdata;

    // ------------------------------------------------------------------
    // Request path
    // ------------------------------------------------------------------
    req_fifo #(
        .FIFO_DEPTH   (FIFO_DEPTH)
    ) u_req_fifo (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_valid    (cmd_valid),
        .cmd_op       (cmd_op),
        .cmd_addr     (cmd_addr),
        .cmd_wdata    (cmd_wdata),
        .cmd_wstrb    (cmd_wstrb),
        .fifo_pop     (fifo_pop),
        .fifo_empty   (fifo_empty),
        .head_op      (head_op),
        .head_addr    (head_addr),
        .head_wdata   (head_wdata),
        .head_wstrb   (head_wstrb),
        .credit_return(credit_return)
    );

    bus_sequencer #(
        .TIMEOUT_CYCLES(TIMEOUT_CYCLES)
    ) u_bus_sequencer (
        .clk          (clk),
        .rst_n        (rst_n),
        .fifo_empty   (fifo_empty),
        .head_op      (head_op),
        .head_addr    (head_addr),
        .head_wdata   (head_wdata),
        .head_wstrb   (head_wstrb),
        .ret_ready    (ret_ready),
        .ret_rdata    (ret_rdata),
        .fifo_pop     (fifo_pop),
        .bus_valid    (bus_valid),
        .bus_write    (bus_write),
        .bus_addr     (bus_addr),
        .bus_wdata    (bus_wdata),
        .bus_wstrb    (bus_wstrb),
        .rsp_valid    (rsp_valid),
        .rsp_rdata    (rsp_rdata),
        .rsp_err      (rsp_err)
    );

    // ------------------------------------------------------------------
    // Slaves on the shared bus
    // ------------------------------------------------------------------
    bram_pack #(
        .BRAM_WORDS   (BRAM_WORDS),
        .BASE_ADDR    (BASE_BRAM)
    ) u_bram (
        .clk          (clk),
        .rst_n        (rst_n),
        .bus_valid    (bus_valid),
        .bus_write    (bus_write),
        .bus_addr     (bus_addr),
        .bus_wdata    (bus_wdata),
        .bus_wstrb    (bus_wstrb),
        .ready        (bram_ready),
        .rdata        (bram_rdata)
    );

    gpio_pack #(
        .BASE_ADDR    (BASE_GPIO)
    ) u_gpio (
        .clk          (clk),
        .rst_n        (rst_n),
        .bus_valid    (bus_valid),
        .bus_write    (bus_write),
        .bus_addr     (bus_addr),
        .bus_wdata    (bus_wdata),
        .bus_wstrb    (bus_wstrb),
        .gpio_in      (gpio_in),
        .ready        (gpio_ready),
        .rdata        (gpio_rdata),
        .gpio_out     (gpio_out)
    );

endmodule

`default_nettype wire

//--- bench/tb_mem_system.sv
`default_nettype none
`timescale 1ns/100ps

module tb_mem_system;
    import mem_bus_pkg::*;
    import mem_map_pkg::*;

    localparam int FIFO_DEPTH     = 4;
    localparam int TIMEOUT_CYCLES = 8;
    localparam int BRAM_WORDS     = 256;
    localparam int RESET_CYCLES   = 4;
    // Columns per request in the stimulus file
    localparam int COLS           = 7;
    localparam int MAX_REQ        = 64;

    logic              clk;
    logic              rst_n;
    logic              cmd_valid;
    mem_op_e           cmd_op;
    logic [ADDR_W-1:0] cmd_addr;
    logic [DATA_W-1:0] cmd_wdata;
    logic [STRB_W-1:0] cmd_wstrb;
    logic [DATA_W-1:0] gpio_in;
    logic              credit_return;
    logic              rsp_valid;
    logic [DATA_W-1:0] rsp_rdata;
    logic              rsp_err;
    logic [DATA_W-1:0] gpio_out;

    logic [31:0]       stim [MAX_REQ*COLS];
    logic [DATA_W-1:0] gpio_model;
    logic [31:0]       rng_state;
    logic              loaded;
    int                num_req;
    int                credits;
    int                sent;
    int                received;
    int                checks;
    int                errors;
    int                rsp_idx;
    int                expect_q [$];

    mem_system #(
        .FIFO_DEPTH    (FIFO_DEPTH),
        .TIMEOUT_CYCLES(TIMEOUT_CYCLES),
        .BRAM_WORDS    (BRAM_WORDS)
    ) u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_valid    (cmd_valid),
        .cmd_op       (cmd_op),
        .cmd_addr     (cmd_addr),
        .cmd_wdata    (cmd_wdata),
        .cmd_wstrb    (cmd_wstrb),
        .gpio_in      (gpio_in),
        .credit_return(credit_return),
        .rsp_valid    (rsp_valid),
        .rsp_rdata    (rsp_rdata),
        .rsp_err      (rsp_err),
        .gpio_out     (gpio_out)
    );

    initial begin
        clk = 1'b0;
    end

    always #2 clk = ~clk;

    // ------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Strobed bytes replace the old word
    function automatic logic [31:0] apply_strobes(input logic [31:0] old_word,
                                                  input logic [31:0] wdata,
                                                  input logic [3:0] wstrb);
        logic [31:0] merged;
        merged = old_word;
        for (int b = 0; b < 4; b++) begin
            if (wstrb[b]) begin
                merged[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return merged;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // One cycle of the host, returned credits counted at the falling edge
    task automatic tick();
        @(negedge clk);
        if (rst_n && credit_return) begin
            credits++;
            if (credits > FIFO_DEPTH) begin
                errors++;
                $display("At %0t ns more credits came back than were spent", $time);
            end
        end
    endtask

    // ------------------------------------------------------------------
    // Response checker, in request order
    // ------------------------------------------------------------------
    always @(negedge clk) begin
        if (rst_n && rsp_valid) begin
            if (expect_q.size() == 0) begin
                errors++;
                $display("At %0t ns a response arrived with no request outstanding", $time);
            end else begin
                rsp_idx = expect_q.pop_front();
                compare_value("rsp_rdata", rsp_rdata, stim[rsp_idx*COLS+4]);
                compare_value("rsp_err", 32'(rsp_err), stim[rsp_idx*COLS+5]);
                if (stim[rsp_idx*COLS] == 32'd1
                        && stim[rsp_idx*COLS+1][31:24] == BASE_GPIO
                        && stim[rsp_idx*COLS+1][23:2] == 22'(GPIO_OUT_OFS)) begin
                    gpio_model = apply_strobes(gpio_model, stim[rsp_idx*COLS+2],
                                               stim[rsp_idx*COLS+3][3:0]);
                end
                compare_value("gpio_out", gpio_out, gpio_model);
                received++;
            end
        end
    end

    initial begin
        wait (loaded);
        repeat (RESET_CYCLES + num_req * (TIMEOUT_CYCLES + 10)) begin
            @(posedge clk);
        end
        $display("Watchdog expired with %0d requests sent and %0d responses received",
                 sent, received);
        $display("Testbench failed");
        $finish;
    end

    // ------------------------------------------------------------------
    // Host
    // ------------------------------------------------------------------
    initial begin
        int   base;
        logic gaps_on;
        rst_n      = 1'b0;
        cmd_valid  = 1'b0;
        cmd_op     = MEM_READ;
        cmd_addr   = '0;
        cmd_wdata  = '0;
        cmd_wstrb  = '0;
        gpio_in    = '0;
        gpio_model = '0;
        rng_state  = 32'd31;
        loaded     = 1'b0;
        credits    = FIFO_DEPTH;
        sent       = 0;
        received   = 0;
        checks     = 0;
        errors     = 0;
        gaps_on    = 1'b0;
        // Unused rows keep an op value that never occurs
        for (int k = 0; k < MAX_REQ*COLS; k++) begin
            stim[k] = 32'hffff_ffff;
        end
        $readmemh("bench/mem_system_stim.txt", stim);
        num_req = 0;
        while (num_req < MAX_REQ && stim[num_req*COLS] != 32'hffff_ffff) begin
            num_req++;
        end
        if (num_req == 0) begin
            errors++;
            $display("The stimulus file held no requests");
        end
        loaded = 1'b1;

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            compare_value("credit_return", 32'(credit_return), 32'd0);
            compare_value("rsp_valid", 32'(rsp_valid), 32'd0);
            compare_value("gpio_out", gpio_out, 32'd0);
        end
        rst_n = 1'b1;

        for (int i = 0; i < num_req; i++) begin
            base = i * COLS;
            // New input value only once nothing is in flight
            if (stim[base+6] != gpio_in) begin
                cmd_valid = 1'b0;
                while (expect_q.size() != 0) begin
                    tick();
                end
                gpio_in = stim[base+6];
            end
            if (gaps_on) begin
                cmd_valid = 1'b0;
                rng_state = xorshift32(rng_state);
                repeat (int'(rng_state[1:0])) begin
                    tick();
                end
            end
            // Back to back until the credits run out, gaps from then on
            while (credits == 0) begin
                cmd_valid = 1'b0;
                gaps_on   = 1'b1;
                tick();
            end
            cmd_valid = 1'b1;
            cmd_op    = mem_op_e'(stim[base][0]);
            cmd_addr  = stim[base+1];
            cmd_wdata = stim[base+2];
            cmd_wstrb = stim[base+3][STRB_W-1:0];
            credits--;
            expect_q.push_back(i);
            sent++;
            tick();
        end
        cmd_valid = 1'b0;

        while (received < num_req) begin
            tick();
        end
        repeat (3) begin
            tick();
        end
        compare_value("credits", 32'(credits), 32'(FIFO_DEPTH));

        $display("Summary: %0d checks, %0d errors, %0d of %0d responses",
                 checks, errors, received, num_req);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/mem_system_stim.txt
// op addr wdata wstrb exp_rdata exp_err gpio_in, all hex, op 0 read 1 write
// RAM at 00xxxxxx, GPIO out at 01000000, GPIO in at 01000004, 05xxxxxx unmapped
1 00000000 11223344 f 00000000 0 00000000
1 00000004 55667788 f 00000000 0 00000000
1 00000008 deadbeef f 00000000 0 00000000
1 0000000c 01234567 f 00000000 0 00000000
0 00000000 00000000 0 11223344 0 00000000
0 00000004 00000000 0 55667788 0 00000000
0 00000008 00000000 0 deadbeef 0 00000000
0 0000000c 00000000 0 01234567 0 00000000
1 00000000 aabbccdd 1 00000000 0 00000000
1 00000004 aabbccdd 6 00000000 0 00000000
1 00000008 00000000 8 00000000 0 00000000
0 00000000 00000000 0 112233dd 0 00000000
0 00000004 00000000 0 55bbcc88 0 00000000
0 00000008 00000000 0 00adbeef 0 00000000
0 00000400 00000000 0 112233dd 0 00000000
1 01000000 cafef00d f 00000000 0 00000000
1 01000000 00001200 2 00000000 0 00000000
0 01000000 00000000 0 cafe120d 0 00000000
0 01000004 00000000 0 5a5a0ff0 0 5a5a0ff0
1 01000004 ffffffff f 00000000 0 5a5a0ff0
0 01000004 00000000 0 5a5a0ff0 0 5a5a0ff0
0 01000008 00000000 0 00000000 0 5a5a0ff0
1 05000000 12345678 f 00000000 1 5a5a0ff0
0 05000010 00000000 0 00000000 1 5a5a0ff0
0 0000000c 00000000 0 01234567 0 5a5a0ff0
0 01000004 00000000 0 00c0ffee 0 00c0ffee

//--- sim.f
common/mem_bus_pkg.sv
common/mem_map_pkg.sv
hw/req_fifo.sv
hw/bus_sequencer.sv
hw/bram_pack.sv
hw/gpio_pack.sv
hw/mem_system.sv
bench/tb_mem_system.sv

//--- run_sim.sh
#!/bin/sh
# Build and run tb_mem_system with Verilator, from the project root

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f sim.f \
    --top-module tb_mem_system -Mdir obj_dir > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build did not succeed"
    exit 1
fi

./obj_dir/Vtb_mem_system > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Testbench failed" "$SIM_LOG"; then
    exit 1
fi
exit 0
